// ==== rtl/mmcm_reconfig_pkg.sv ====
package mmcm_reconfig_pkg;

   typedef logic [6:0]  drp_addr_t;
   typedef logic [15:0] drp_data_t;
   typedef logic [9:0]  filter_cfg_t;  // Loop filter bits, scattered over two registers

   typedef struct packed {
      logic [2:0] phase_mux;
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_sel;
      logic       no_count;
      logic [5:0] delay_time;
   } divider_cfg_t;

   typedef struct packed {
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_sel;
      logic       no_count;
   } divclk_cfg_t;

   typedef struct packed {
      divider_cfg_t [6:0] clkout;
      divider_cfg_t       clkfbout;
      divclk_cfg_t        divclk;
   } mmcm_cfg_t;

   typedef struct packed {
      logic [4:0] ref_dly;
      logic [4:0] fb_dly;
      logic [9:0] lock_cnt;
      logic [9:0] unlock_cnt;
      logic [9:0] sat_high;
   } lock_cfg_t;

   // Same 16-bit divider word, first or second register of the pair
   typedef union packed {
      struct packed {
         logic [2:0] phase_mux;
         logic       rsvd;
         logic [5:0] high_time;
         logic [5:0] low_time;
      } reg1;
      struct packed {
         logic [7:0] rsvd;  // Fractional fields live here on CLKOUT0/CLKFBOUT
         logic       edge_sel;
         logic       no_count;
         logic [5:0] delay_time;
      } reg2;
   } drp_word_u;

   typedef struct packed {
      drp_addr_t addr;
      drp_data_t mask;  // Bits of the read word that survive
      drp_data_t data;
   } step_entry_t;

   typedef enum logic [4:0] {
      step_power,
      step_clkout0_reg1, step_clkout0_reg2,
      step_clkout1_reg1, step_clkout1_reg2,
      step_clkout2_reg1, step_clkout2_reg2,
      step_clkout3_reg1, step_clkout3_reg2,
      step_clkout4_reg1, step_clkout4_reg2,
      step_clkout5_reg1, step_clkout5_reg2,
      step_clkout6_reg1, step_clkout6_reg2,
      step_divclk,
      step_clkfbout_reg1, step_clkfbout_reg2,
      step_lock_reg1, step_lock_reg2, step_lock_reg3,
      step_filt_reg1, step_filt_reg2
   } step_t;

   localparam int num_steps = int'(step_filt_reg2) + 1;

   localparam drp_addr_t addr_clkout5_reg1  = 7'h06;
   localparam drp_addr_t addr_clkout5_reg2  = 7'h07;
   localparam drp_addr_t addr_clkout0_reg1  = 7'h08;
   localparam drp_addr_t addr_clkout0_reg2  = 7'h09;
   localparam drp_addr_t addr_clkout1_reg1  = 7'h0a;
   localparam drp_addr_t addr_clkout1_reg2  = 7'h0b;
   localparam drp_addr_t addr_clkout2_reg1  = 7'h0c;
   localparam drp_addr_t addr_clkout2_reg2  = 7'h0d;
   localparam drp_addr_t addr_clkout3_reg1  = 7'h0e;
   localparam drp_addr_t addr_clkout3_reg2  = 7'h0f;
   localparam drp_addr_t addr_clkout4_reg1  = 7'h10;
   localparam drp_addr_t addr_clkout4_reg2  = 7'h11;
   localparam drp_addr_t addr_clkout6_reg1  = 7'h12;  // Absent on the small tile
   localparam drp_addr_t addr_clkout6_reg2  = 7'h13;
   localparam drp_addr_t addr_clkfbout_reg1 = 7'h14;
   localparam drp_addr_t addr_clkfbout_reg2 = 7'h15;
   localparam drp_addr_t addr_divclk        = 7'h16;
   localparam drp_addr_t addr_lock_reg1     = 7'h18;
   localparam drp_addr_t addr_lock_reg2     = 7'h19;
   localparam drp_addr_t addr_lock_reg3     = 7'h1a;
   localparam drp_addr_t addr_power         = 7'h28;
   localparam drp_addr_t addr_filt_reg1     = 7'h4e;
   localparam drp_addr_t addr_filt_reg2     = 7'h4f;

   localparam drp_data_t mask_power       = 16'h0000;
   localparam drp_data_t mask_div_reg1    = 16'h1000;
   localparam drp_data_t mask_frac_reg2   = 16'h8000;  // CLKOUT0 and CLKFBOUT
   localparam drp_data_t mask_div_reg2    = 16'hfc00;  // CLKOUT1 to CLKOUT4
   localparam drp_data_t mask_shared_reg2 = 16'hc000;  // CLKOUT5 and CLKOUT6
   localparam drp_data_t mask_divclk      = 16'hc000;
   localparam drp_data_t mask_lock_reg1   = 16'hfc00;
   localparam drp_data_t mask_lock_reg2   = 16'h8000;
   localparam drp_data_t mask_lock_reg3   = 16'h8000;
   localparam drp_data_t mask_filt_reg1   = 16'h66ff;
   localparam drp_data_t mask_filt_reg2   = 16'h666f;

endpackage

// ==== rtl/lock_filter_table.sv ====
module lock_filter_table import mmcm_reconfig_pkg::*; (
   input  logic        dclk,
   input  logic [6:0]  divclk_cnt,  // Bit 6 set means count out of range
   output lock_cfg_t   lock,
   output filter_cfg_t filter
);

   logic [5:0]  idx;
   logic [4:0]  dly;
   logic [9:0]  lock_cnt;
   filter_cfg_t filter_nxt;

   assign idx = divclk_cnt[6] ? 6'd0 : divclk_cnt[5:0];

   // Reference and feedback delay are always equal
   always_comb begin
      case (idx) inside
         [0:1]:   dly = 5'd6;
         6'd2:    dly = 5'd8;
         6'd3:    dly = 5'd11;
         6'd4:    dly = 5'd14;
         6'd5:    dly = 5'd17;
         6'd6:    dly = 5'd19;
         6'd7:    dly = 5'd22;
         6'd8:    dly = 5'd25;
         6'd9:    dly = 5'd28;
         default: dly = 5'd31;
      endcase
   end

   always_comb begin
      case (idx) inside
         [0:9]:   lock_cnt = 10'd1000;
         6'd10:   lock_cnt = 10'd900;
         6'd11:   lock_cnt = 10'd825;
         6'd12:   lock_cnt = 10'd750;
         6'd13:   lock_cnt = 10'd700;
         6'd14:   lock_cnt = 10'd650;
         6'd15:   lock_cnt = 10'd625;
         6'd16:   lock_cnt = 10'd575;
         6'd17:   lock_cnt = 10'd550;
         6'd18:   lock_cnt = 10'd525;
         6'd19:   lock_cnt = 10'd500;
         6'd20:   lock_cnt = 10'd475;
         6'd21:   lock_cnt = 10'd450;
         6'd22:   lock_cnt = 10'd425;
         [23:24]: lock_cnt = 10'd400;
         6'd25:   lock_cnt = 10'd375;
         [26:27]: lock_cnt = 10'd350;
         [28:29]: lock_cnt = 10'd325;
         [30:32]: lock_cnt = 10'd300;
         [33:35]: lock_cnt = 10'd275;
         default: lock_cnt = 10'd250;
      endcase
   end

   // Optimized bandwidth settings
   always_comb begin
      case (idx) inside
         6'd0:             filter_nxt = 10'b0010_1111_00;
         6'd1:             filter_nxt = 10'b0100_1111_00;
         6'd2:             filter_nxt = 10'b0101_1011_00;
         6'd3:             filter_nxt = 10'b0111_0111_00;
         6'd4:             filter_nxt = 10'b1101_0111_00;
         6'd5:             filter_nxt = 10'b1110_1011_00;
         6'd6:             filter_nxt = 10'b1110_1101_00;
         6'd7:             filter_nxt = 10'b1111_0011_00;
         6'd8:             filter_nxt = 10'b1110_0101_00;
         6'd9, [16:17]:    filter_nxt = 10'b1111_0101_00;
         6'd10, [12:15]:   filter_nxt = 10'b1111_1001_00;
         6'd11:            filter_nxt = 10'b1101_0001_00;
         [18:20]:          filter_nxt = 10'b1100_0001_00;
         [21:24]:          filter_nxt = 10'b0101_1100_00;
         [25:40]:          filter_nxt = 10'b0011_0100_00;
         [41:45]:          filter_nxt = 10'b0010_1000_00;
         [46:47]:          filter_nxt = 10'b0111_0001_00;
         [48:51]:          filter_nxt = 10'b0100_1100_00;
         [52:53]:          filter_nxt = 10'b0110_0001_00;
         [54:56]:          filter_nxt = 10'b0101_0110_00;
         [57:60]:          filter_nxt = 10'b0010_0100_00;
         6'd61:            filter_nxt = 10'b0100_1010_00;
         default:          filter_nxt = 10'b0011_1100_00;  // 62 and 63
      endcase
   end

   always_ff @(posedge dclk) begin
      lock   <= '{ref_dly: dly, fb_dly: dly, lock_cnt: lock_cnt,
                  unlock_cnt: 10'd1001, sat_high: 10'd1};
      filter <= filter_nxt;
   end

endmodule

// ==== rtl/drp_word_builder.sv ====
module drp_word_builder import mmcm_reconfig_pkg::*; #(
   parameter bit has_clkout6 = 1'b1
) (
   input  mmcm_cfg_t   cfg,
   input  step_t       step,
   input  lock_cfg_t   lock,
   input  filter_cfg_t filter,
   output step_entry_t entry,
   output logic [6:0]  divclk_cnt
);

   step_t     eff_step;
   drp_data_t divclk_word;
   drp_data_t lock_word1;
   drp_data_t lock_word2;
   drp_data_t lock_word3;
   drp_data_t filt_word1;
   drp_data_t filt_word2;

   function automatic drp_data_t div_reg1(input divider_cfg_t d);
      drp_word_u w;
      w.reg1.phase_mux = d.phase_mux;
      w.reg1.rsvd      = 1'b0;
      w.reg1.high_time = d.high_time;
      w.reg1.low_time  = d.low_time;
      return w;
   endfunction

   function automatic drp_data_t div_reg2(input divider_cfg_t d);
      drp_word_u w;
      w.reg2.rsvd       = 8'h00;  // No fractional divide
      w.reg2.edge_sel   = d.edge_sel;
      w.reg2.no_count   = d.no_count;
      w.reg2.delay_time = d.delay_time;
      return w;
   endfunction

   // Wraps past 63 when high plus low is zero, flagged by bit 6
   assign divclk_cnt = cfg.divclk.no_count ? 7'd0 :
                       7'(cfg.divclk.high_time) + 7'(cfg.divclk.low_time) - 7'd1;

   assign divclk_word = {2'b00, cfg.divclk.edge_sel, cfg.divclk.no_count,
                         cfg.divclk.high_time, cfg.divclk.low_time};

   assign lock_word1 = {6'b000000, lock.lock_cnt};
   assign lock_word2 = {1'b0, lock.fb_dly, lock.sat_high};
   assign lock_word3 = {1'b0, lock.ref_dly, lock.unlock_cnt};

   assign filt_word1 = {filter[9], 2'b00, filter[8:7], 2'b00, filter[6], 8'h00};
   assign filt_word2 = {filter[5], 2'b00, filter[4:3], 2'b00, filter[2:1], 2'b00,
                        filter[0], 4'h0};

   always_comb begin
      eff_step = step;
      if (!has_clkout6 && step >= step_clkout6_reg1)
         eff_step = step_t'(step + 5'd2);  // Hop over the CLKOUT6 pair
   end

   always_comb begin
      case (eff_step)
         step_power:         entry = '{addr_power, mask_power, 16'hffff};
         step_clkout0_reg1:  entry = '{addr_clkout0_reg1, mask_div_reg1, div_reg1(cfg.clkout[0])};
         step_clkout0_reg2:  entry = '{addr_clkout0_reg2, mask_frac_reg2, div_reg2(cfg.clkout[0])};
         step_clkout1_reg1:  entry = '{addr_clkout1_reg1, mask_div_reg1, div_reg1(cfg.clkout[1])};
         step_clkout1_reg2:  entry = '{addr_clkout1_reg2, mask_div_reg2, div_reg2(cfg.clkout[1])};
         step_clkout2_reg1:  entry = '{addr_clkout2_reg1, mask_div_reg1, div_reg1(cfg.clkout[2])};
         step_clkout2_reg2:  entry = '{addr_clkout2_reg2, mask_div_reg2, div_reg2(cfg.clkout[2])};
         step_clkout3_reg1:  entry = '{addr_clkout3_reg1, mask_div_reg1, div_reg1(cfg.clkout[3])};
         step_clkout3_reg2:  entry = '{addr_clkout3_reg2, mask_div_reg2, div_reg2(cfg.clkout[3])};
         step_clkout4_reg1:  entry = '{addr_clkout4_reg1, mask_div_reg1, div_reg1(cfg.clkout[4])};
         step_clkout4_reg2:  entry = '{addr_clkout4_reg2, mask_div_reg2, div_reg2(cfg.clkout[4])};
         step_clkout5_reg1:  entry = '{addr_clkout5_reg1, mask_div_reg1, div_reg1(cfg.clkout[5])};
         step_clkout5_reg2:  entry = '{addr_clkout5_reg2, mask_shared_reg2,
                                       div_reg2(cfg.clkout[5])};
         step_clkout6_reg1:  entry = '{addr_clkout6_reg1, mask_div_reg1, div_reg1(cfg.clkout[6])};
         step_clkout6_reg2:  entry = '{addr_clkout6_reg2, mask_shared_reg2,
                                       div_reg2(cfg.clkout[6])};
         step_divclk:        entry = '{addr_divclk, mask_divclk, divclk_word};
         step_clkfbout_reg1: entry = '{addr_clkfbout_reg1, mask_div_reg1, div_reg1(cfg.clkfbout)};
         step_clkfbout_reg2: entry = '{addr_clkfbout_reg2, mask_frac_reg2, div_reg2(cfg.clkfbout)};
         step_lock_reg1:     entry = '{addr_lock_reg1, mask_lock_reg1, lock_word1};
         step_lock_reg2:     entry = '{addr_lock_reg2, mask_lock_reg2, lock_word2};
         step_lock_reg3:     entry = '{addr_lock_reg3, mask_lock_reg3, lock_word3};
         step_filt_reg1:     entry = '{addr_filt_reg1, mask_filt_reg1, filt_word1};
         step_filt_reg2:     entry = '{addr_filt_reg2, mask_filt_reg2, filt_word2};
         default:            entry = '0;
      endcase
   end

endmodule

// ==== rtl/drp_sequencer.sv ====
module drp_sequencer import mmcm_reconfig_pkg::*; #(
   parameter bit has_clkout6 = 1'b1
) (
   input  logic        dclk,
   input  logic        rst,
   input  logic        start_reconfig,
   output logic        ready,
   output logic        reconfig_done,
   input  logic        locked,
   output logic        rst_mmcm,
   input  step_entry_t entry,
   output step_t       step,
   output drp_addr_t   daddr,
   output drp_data_t   din,
   output logic        den,
   output logic        dwe,
   input  drp_data_t   dout,
   input  logic        drdy
);

   // Run is two steps shorter without CLKOUT6
   localparam step_t last_step = step_t'(has_clkout6 ? num_steps - 1 : num_steps - 3);

   typedef enum logic [3:0] {
      st_restart,
      st_wait_lock,
      st_wait_start,
      st_read_issue,
      st_read_wait,
      st_mask,
      st_merge,
      st_write_issue,
      st_write_wait
   } state_t;

   state_t state;

   always_ff @(posedge dclk) begin
      if (rst) begin
         state         <= st_restart;
         step          <= step_power;
         ready         <= 1'b0;
         reconfig_done <= 1'b0;
         rst_mmcm      <= 1'b1;
         den           <= 1'b0;
         dwe           <= 1'b0;
      end else begin
         den           <= 1'b0;  // Strobes last a single cycle
         dwe           <= 1'b0;
         reconfig_done <= 1'b0;
         case (state)
            st_restart: begin
               rst_mmcm <= 1'b0;
               step     <= step_power;
               state    <= st_wait_lock;
            end
            st_wait_lock: begin
               if (locked) begin
                  ready <= 1'b1;
                  state <= st_wait_start;
               end
            end
            st_wait_start: begin
               step <= step_power;
               if (start_reconfig) begin
                  ready <= 1'b0;
                  state <= st_read_issue;
               end
            end
            st_read_issue: begin
               den      <= 1'b1;
               rst_mmcm <= 1'b1;  // Tile held in reset until the last write lands
               state    <= st_read_wait;
            end
            st_read_wait: begin
               if (drdy)
                  state <= st_mask;
            end
            st_mask:  state <= st_merge;
            st_merge: state <= st_write_issue;
            st_write_issue: begin
               den   <= 1'b1;
               dwe   <= 1'b1;
               step  <= step_t'(step + 1'b1);
               state <= st_write_wait;
            end
            st_write_wait: begin
               if (drdy) begin
                  // Step already advanced past the one just written
                  if (step > last_step) begin
                     reconfig_done <= 1'b1;
                     rst_mmcm      <= 1'b0;
                     state         <= st_wait_lock;
                  end else begin
                     state <= st_read_issue;
                  end
               end
            end
            default: state <= st_restart;
         endcase
      end
   end

   // DRP address is held from the read through the write of a step
   always_ff @(posedge dclk) begin
      case (state)
         st_read_issue: daddr <= entry.addr;
         st_read_wait: begin
            if (drdy)
               din <= dout;  // Capture the current register value
         end
         st_mask:  din <= din & entry.mask;
         st_merge: din <= din | entry.data;
         default:  din <= din;
      endcase
   end

endmodule

// ==== rtl/mmcm_reconfig_top.sv ====
module mmcm_reconfig_top import mmcm_reconfig_pkg::*; #(
   parameter bit has_clkout6 = 1'b1
) (
   input  logic      dclk,
   input  logic      rst,
   input  mmcm_cfg_t cfg,  // Held stable for the whole run
   input  logic      start_reconfig,
   output logic      ready,
   output logic      reconfig_done,
   output drp_addr_t daddr,
   output drp_data_t din,
   output logic      den,
   output logic      dwe,
   input  drp_data_t dout,
   input  logic      drdy,
   output logic      rst_mmcm,
   input  logic      locked
);

   step_t       step;
   step_entry_t entry;
   logic [6:0]  divclk_cnt;
   lock_cfg_t   lock;
   filter_cfg_t filter;

   drp_sequencer #(.has_clkout6(has_clkout6)) u_sequencer (
      .dclk           (dclk),
      .rst            (rst),
      .start_reconfig (start_reconfig),
      .ready          (ready),
      .reconfig_done  (reconfig_done),
      .locked         (locked),
      .rst_mmcm       (rst_mmcm),
      .entry          (entry),
      .step           (step),
      .daddr          (daddr),
      .din            (din),
      .den            (den),
      .dwe            (dwe),
      .dout           (dout),
      .drdy           (drdy)
   );

   drp_word_builder #(.has_clkout6(has_clkout6)) u_word_builder (
      .cfg        (cfg),
      .step       (step),
      .lock       (lock),
      .filter     (filter),
      .entry      (entry),
      .divclk_cnt (divclk_cnt)
   );

   lock_filter_table u_lock_filter (
      .dclk       (dclk),
      .divclk_cnt (divclk_cnt),
      .lock       (lock),
      .filter     (filter)
   );

endmodule

// ==== testbench/drp_tile_model.sv ====
module drp_tile_model import mmcm_reconfig_pkg::*; (
   input  logic      dclk,
   input  logic      rst,
   input  drp_addr_t daddr,
   input  drp_data_t din,
   input  logic      den,
   input  logic      dwe,
   output drp_data_t dout,
   output logic      drdy,
   input  logic      rst_mmcm,
   output logic      locked
);

   drp_data_t   mem [0:127];
   logic        busy;
   logic [1:0]  wait_cnt;
   drp_addr_t   pend_addr;
   drp_data_t   pend_data;
   logic        pend_we;
   logic [3:0]  lock_wait;
   logic [31:0] seed;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Every address bit shows up in the preload value
   function automatic drp_data_t preload_word(input int a);
      logic [6:0] av;
      av = 7'(a);
      return {av, ~av, av[1:0]} ^ 16'h5a3c;
   endfunction

   always_ff @(posedge dclk) begin
      if (rst) begin
         for (int i = 0; i < 128; i++)
            mem[i] <= preload_word(i);
         busy      <= 1'b0;
         wait_cnt  <= 2'd0;
         drdy      <= 1'b0;
         dout      <= '0;
         locked    <= 1'b0;
         lock_wait <= 4'd3;
         seed      <= 32'd72;
      end else begin
         drdy <= 1'b0;
         if (den && !busy) begin
            busy      <= 1'b1;
            pend_addr <= daddr;
            pend_data <= din;
            pend_we   <= dwe;
            wait_cnt  <= seed[17:16];  // drdy after 1 to 4 cycles
            seed      <= lcg_next(seed);
         end else if (busy) begin
            if (wait_cnt == 2'd0) begin
               drdy <= 1'b1;
               busy <= 1'b0;
               if (pend_we)
                  mem[pend_addr] <= pend_data;
               else
                  dout <= mem[pend_addr];
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
            end
         end
         if (rst_mmcm) begin
            locked    <= 1'b0;
            lock_wait <= 4'd2 + {1'b0, seed[20:18]};  // Lock 3 to 10 cycles later
         end else if (!locked) begin
            if (lock_wait == 4'd0)
               locked <= 1'b1;
            else
               lock_wait <= lock_wait - 4'd1;
         end
      end
   end

endmodule

// ==== testbench/tb_mmcm_reconfig.sv ====
module tb_mmcm_reconfig import mmcm_reconfig_pkg::*; ();

   localparam int num_tests   = 5;
   localparam int cycle_limit = 400 * num_tests + 100;

   logic        dclk;
   logic        rst;
   mmcm_cfg_t   cfg;
   logic        start_reconfig;
   logic        ready;
   logic        reconfig_done;
   drp_addr_t   daddr;
   drp_data_t   din;
   logic        den;
   logic        dwe;
   drp_data_t   dout;
   logic        drdy;
   logic        rst_mmcm;
   logic        locked;

   logic [23:0] vec [0:8*num_tests-1];
   drp_addr_t   exp_addr [0:num_steps-1];
   drp_data_t   exp_mask [0:num_steps-1];
   drp_data_t   exp_data [0:num_steps-1];
   drp_data_t   shadow [0:127];
   int          write_idx;
   int          done_count;
   int          error_count;
   int          cycles;
   int          pass_count;
   int          fail_count;
   logic        outstanding;
   logic        wr_pending;
   logic        final_drdy;
   drp_addr_t   last_read_addr;
   logic        ready_q;
   logic        locked_q;
   logic        start_q;

   mmcm_reconfig_top #(.has_clkout6(1'b1)) u_dut (
      .dclk           (dclk),
      .rst            (rst),
      .cfg            (cfg),
      .start_reconfig (start_reconfig),
      .ready          (ready),
      .reconfig_done  (reconfig_done),
      .daddr          (daddr),
      .din            (din),
      .den            (den),
      .dwe            (dwe),
      .dout           (dout),
      .drdy           (drdy),
      .rst_mmcm       (rst_mmcm),
      .locked         (locked)
   );

   drp_tile_model u_tile (
      .dclk     (dclk),
      .rst      (rst),
      .daddr    (daddr),
      .din      (din),
      .den      (den),
      .dwe      (dwe),
      .dout     (dout),
      .drdy     (drdy),
      .rst_mmcm (rst_mmcm),
      .locked   (locked)
   );

   initial begin
      dclk = 1'b0;
      forever #5 dclk = ~dclk;
   end

   function automatic drp_data_t div_word1(input divider_cfg_t d);
      return {d.phase_mux, 1'b0, d.high_time, d.low_time};
   endfunction

   function automatic drp_data_t div_word2(input divider_cfg_t d);
      return {8'h00, d.edge_sel, d.no_count, d.delay_time};
   endfunction

   task automatic set_step(input int s, input drp_addr_t a, input drp_data_t m,
                           input drp_data_t d);
      exp_addr[s] = a;
      exp_mask[s] = m;
      exp_data[s] = d;
   endtask

   // Expected step list in run order with table words from the vector file
   task automatic build_expected(input int t);
      mmcm_cfg_t c;
      c = cfg;
      set_step(0, addr_power, 16'h0000, 16'hffff);
      set_step(1, addr_clkout0_reg1, 16'h1000, div_word1(c.clkout[0]));
      set_step(2, addr_clkout0_reg2, 16'h8000, div_word2(c.clkout[0]));
      set_step(3, addr_clkout1_reg1, 16'h1000, div_word1(c.clkout[1]));
      set_step(4, addr_clkout1_reg2, 16'hfc00, div_word2(c.clkout[1]));
      set_step(5, addr_clkout2_reg1, 16'h1000, div_word1(c.clkout[2]));
      set_step(6, addr_clkout2_reg2, 16'hfc00, div_word2(c.clkout[2]));
      set_step(7, addr_clkout3_reg1, 16'h1000, div_word1(c.clkout[3]));
      set_step(8, addr_clkout3_reg2, 16'hfc00, div_word2(c.clkout[3]));
      set_step(9, addr_clkout4_reg1, 16'h1000, div_word1(c.clkout[4]));
      set_step(10, addr_clkout4_reg2, 16'hfc00, div_word2(c.clkout[4]));
      set_step(11, addr_clkout5_reg1, 16'h1000, div_word1(c.clkout[5]));
      set_step(12, addr_clkout5_reg2, 16'hc000, div_word2(c.clkout[5]));
      set_step(13, addr_clkout6_reg1, 16'h1000, div_word1(c.clkout[6]));
      set_step(14, addr_clkout6_reg2, 16'hc000, div_word2(c.clkout[6]));
      set_step(15, addr_divclk, 16'hc000, {2'b00, c.divclk.edge_sel, c.divclk.no_count,
                                           c.divclk.high_time, c.divclk.low_time});
      set_step(16, addr_clkfbout_reg1, 16'h1000, div_word1(c.clkfbout));
      set_step(17, addr_clkfbout_reg2, 16'h8000, div_word2(c.clkfbout));
      set_step(18, addr_lock_reg1, 16'hfc00, vec[8*t+3][15:0]);
      set_step(19, addr_lock_reg2, 16'h8000, vec[8*t+4][15:0]);
      set_step(20, addr_lock_reg3, 16'h8000, vec[8*t+5][15:0]);
      set_step(21, addr_filt_reg1, 16'h66ff, vec[8*t+6][15:0]);
      set_step(22, addr_filt_reg2, 16'h666f, vec[8*t+7][15:0]);
   endtask

   // DRP bus and control monitor
   always @(posedge dclk) begin
      if (!rst) begin
         if (den && outstanding) begin
            $display("Time %0t: den raised while an access was outstanding", $time);
            error_count++;
         end
         if (ready && !ready_q && !locked_q) begin
            $display("Time %0t: ready rose without locked", $time);
            error_count++;
         end
         if (ready_q && !ready && !start_q) begin
            $display("Time %0t: ready dropped without start_reconfig", $time);
            error_count++;
         end
         if (den && !dwe)
            last_read_addr <= daddr;
         if (den && dwe) begin
            if (write_idx >= num_steps) begin
               $display("Time %0t: extra write to address %h", $time, daddr);
               error_count++;
            end else begin
               if (daddr != last_read_addr || daddr != exp_addr[write_idx]) begin
                  $display("FAIL %0t: step %0d wrote address %h, expected %h", $time,
                           write_idx, daddr, exp_addr[write_idx]);
                  error_count++;
               end
               if (din != ((shadow[daddr] & exp_mask[write_idx]) | exp_data[write_idx])) begin
                  $display("FAIL %0t: step %0d wrote %h, expected %h", $time, write_idx,
                           din, (shadow[daddr] & exp_mask[write_idx]) | exp_data[write_idx]);
                  error_count++;
               end
               if (!rst_mmcm) begin
                  $display("Time %0t: tile reset low during a write", $time);
                  error_count++;
               end
               shadow[daddr] <= (shadow[daddr] & exp_mask[write_idx]) | exp_data[write_idx];
            end
            write_idx     <= write_idx + 1;
         end
         if (den) begin
            outstanding <= 1'b1;
            wr_pending  <= dwe;
         end else if (drdy) begin
            outstanding <= 1'b0;
         end
         final_drdy <= drdy && wr_pending && write_idx == num_steps;
         if (reconfig_done) begin
            done_count <= done_count + 1;
            if (!final_drdy) begin
               $display("FAIL %0t: reconfig_done not one cycle after the final drdy", $time);
               error_count++;
            end
            if (rst_mmcm) begin
               $display("FAIL %0t: tile reset still high at reconfig_done", $time);
               error_count++;
            end
         end else if (final_drdy) begin
            $display("FAIL %0t: reconfig_done missing after the final drdy", $time);
            error_count++;
         end
      end
      ready_q  <= ready;
      locked_q <= locked;
      start_q  <= start_reconfig;
   end

   always @(posedge dclk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Run timed out after %0d cycles", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      int errs_before;
      int done_before;
      logic [6:0] a;
      mmcm_cfg_t test_cfg;
      rst            = 1'b1;
      cfg            = '0;
      start_reconfig = 1'b0;
      cycles         = 0;
      error_count    = 0;
      pass_count     = 0;
      fail_count     = 0;
      write_idx      = 0;
      done_count     = 0;
      outstanding    = 1'b0;
      wr_pending     = 1'b0;
      final_drdy     = 1'b0;
      last_read_addr = '0;
      ready_q        = 1'b0;
      locked_q       = 1'b0;
      start_q        = 1'b0;
      for (int i = 0; i < 128; i++) begin
         a = 7'(i);
         shadow[i] = {a, ~a, a[1:0]} ^ 16'h5a3c;
      end
      $readmemh("testbench/reconfig_input.txt", vec);
      repeat (4) @(posedge dclk);
      rst <= 1'b0;
      @(posedge dclk);
      #1;
      if (den || dwe || ready) begin
         $display("FAIL %0t: den, dwe or ready high after reset", $time);
         error_count++;
      end
      for (int t = 0; t < num_tests; t++) begin
         while (!ready)
            @(posedge dclk);
         errs_before = error_count;
         done_before = done_count;
         for (int i = 0; i < 7; i++)
            test_cfg.clkout[i] = divider_cfg_t'(vec[8*t][22:0] ^ 23'(i));
         test_cfg.clkfbout = divider_cfg_t'(vec[8*t+1][22:0]);
         test_cfg.divclk   = divclk_cfg_t'(vec[8*t+2][13:0]);
         cfg            <= test_cfg;
         start_reconfig <= 1'b1;
         write_idx <= 0;
         @(posedge dclk);
         start_reconfig <= 1'b0;
         build_expected(t);
         while (!reconfig_done)
            @(posedge dclk);
         @(posedge dclk);
         if (write_idx != num_steps || done_count != done_before + 1) begin
            $display("Test %0d wrote %0d registers with %0d done pulses", t, write_idx,
                     done_count - done_before);
            error_count++;
         end
         if (error_count == errs_before) begin
            pass_count++;
            $display("Test %0d: pass", t);
         end else begin
            fail_count++;
            $display("Test %0d: fail", t);
         end
      end
      while (!ready)
         @(posedge dclk);
      $display("Tests passed %0d failed %0d", pass_count, fail_count);
      if (error_count == 0 && fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== testbench/reconfig_input.txt ====
// clkout base, clkfbout, divclk, lock1, lock2, lock3, filt1, filt2 (hex)
// clkout[i] is the base with i XORed in; lock and filter are field data words
2a5c93 1e2d3c 0104 03e8 1801 1be9 1000 9900
51b3e7 4b5a69 0516 03e8 7001 73e9 9900 1100
0c7d2a 6789ab 0a28 01f4 7c01 7fe9 9000 0100
// Zero high and low times wrap out of range
7f0f0f 001122 0000 03e8 1801 1be9 0800 9900
13579b 3a2b1c 207c 00fa 7c01 7fe9 0900 9000

// ==== project.f ====
rtl/mmcm_reconfig_pkg.sv
rtl/lock_filter_table.sv
rtl/drp_word_builder.sv
rtl/drp_sequencer.sv
rtl/mmcm_reconfig_top.sv
testbench/drp_tile_model.sv
testbench/tb_mmcm_reconfig.sv
